// ==== Bender.yml ====
package:
  name: color_tracker

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hw/video_pkg.sv
      - hw/tracker_pkg.sv
      - hw/color_mask.sv
      - hw/bounding_box.sv
      - hw/center_of_mass.sv
      - hw/color_tracker_top.sv
      - target: test
        files:
          - testbench/tb_color_tracker.sv

// ==== build.f ====
+incdir+include
hw/video_pkg.sv
hw/tracker_pkg.sv
hw/color_mask.sv
hw/bounding_box.sv
hw/center_of_mass.sv
hw/color_tracker_top.sv
testbench/tb_color_tracker.sv

// ==== hw/bounding_box.sv ====
module bounding_box (
  input  logic                    clk_pixel,
  input  logic                    sys_rst,
  input  tracker_pkg::mask_beat_t mask,
  output tracker_pkg::bbox_t      bbox,
  output logic                    bbox_valid
);
  import tracker_pkg::*;

  // running box starts inverted so the first hit loads every edge
  localparam bbox_t BOX_START = '{
    empty: 1'b1,
    x_min: '1,
    y_min: '1,
    x_max: '0,
    y_max: '0
  };

  // what a frame without hits reports
  localparam bbox_t BOX_EMPTY = '{
    empty: 1'b1,
    x_min: '0,
    y_min: '0,
    x_max: '0,
    y_max: '0
  };

  bbox_t run;    // box of the frame in progress where empty doubles as not-seen-any
  logic  marked;

  assign marked = mask.valid && mask.hit;

  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      run        <= BOX_START;
      bbox       <= BOX_EMPTY;
      bbox_valid <= 1'b0;
    end else begin
      bbox_valid <= mask.frame_end; // one cycle after the frame_end beat
      if (mask.frame_end) begin
        // publish and restart in the same cycle
        if (run.empty) bbox <= BOX_EMPTY;
        else           bbox <= run;
        run <= BOX_START;
      end else if (marked) begin
        run.empty <= 1'b0;
        if (mask.x < run.x_min) run.x_min <= mask.x;
        if (mask.x > run.x_max) run.x_max <= mask.x;
        if (mask.y < run.y_min) run.y_min <= mask.y;
        if (mask.y > run.y_max) run.y_max <= mask.y;
      end
    end
  end

endmodule

// ==== hw/center_of_mass.sv ====
`include "tracker_defines.svh"

module center_of_mass (
  input  logic                    clk_pixel,
  input  logic                    sys_rst,
  input  tracker_pkg::mask_beat_t mask,
  output tracker_pkg::com_t       com,
  output logic                    com_valid
);
  import tracker_pkg::*;

  // y dividend is zero extended so both dividers share one step count
  localparam int STEPS  = `TRK_SUM_X_W;
  localparam int STEP_W = $clog2(STEPS);

  localparam com_t COM_EMPTY = '{empty: 1'b1, x: '0, y: '0};

  // restoring divider state where quotient bits shift in from the right
  typedef struct packed {
    logic [`TRK_CNT_W-1:0] rem; // always below the divisor
    logic [STEPS-1:0]      quo; // dividend on load and quotient when done
  } div_state_t;

  logic [`TRK_SUM_X_W-1:0] acc_x;
  logic [`TRK_SUM_Y_W-1:0] acc_y;
  logic [`TRK_CNT_W-1:0]   acc_cnt;

  logic                  busy;
  logic [STEP_W-1:0]     step;
  logic [`TRK_CNT_W-1:0] den;  // hit count of the frame being divided
  div_state_t            div_x;
  div_state_t            div_y;
  div_state_t            div_x_nxt;
  div_state_t            div_y_nxt;
  logic                  last_step;

  // one quotient bit per call
  function automatic div_state_t div_step(input div_state_t cur,
                                          input logic [`TRK_CNT_W-1:0] d);
    logic [`TRK_CNT_W:0] shifted;
    logic [`TRK_CNT_W:0] diff;
    div_state_t          nxt;
    shifted = {cur.rem, cur.quo[STEPS-1]}; // bring down next dividend bit
    diff    = shifted - {1'b0, d};
    nxt.quo = {cur.quo[STEPS-2:0], 1'b0};
    if (shifted >= {1'b0, d}) begin
      nxt.rem    = diff[`TRK_CNT_W-1:0];
      nxt.quo[0] = 1'b1;
    end else begin
      nxt.rem = shifted[`TRK_CNT_W-1:0]; // below d so it fits
    end
    return nxt;
  endfunction

  assign div_x_nxt = div_step(div_x, den);
  assign div_y_nxt = div_step(div_y, den);
  assign last_step = busy && (step == STEP_W'(STEPS - 1));

  // per frame accumulation that every frame_end restarts
  always_ff @(posedge clk_pixel) begin
    if (sys_rst || mask.frame_end) begin
      acc_x   <= '0;
      acc_y   <= '0;
      acc_cnt <= '0;
    end else if (mask.valid && mask.hit) begin
      acc_x   <= acc_x + `TRK_SUM_X_W'(mask.x);
      acc_y   <= acc_y + `TRK_SUM_Y_W'(mask.y);
      acc_cnt <= acc_cnt + 1'b1;
    end
  end

  // divider datapath loads only when idle so a late frame_end is dropped
  always_ff @(posedge clk_pixel) begin
    if (!busy && mask.frame_end) begin
      den   <= acc_cnt;
      div_x <= '{rem: '0, quo: acc_x};
      div_y <= '{rem: '0, quo: STEPS'(acc_y)};
    end else if (busy) begin
      div_x <= div_x_nxt;
      div_y <= div_y_nxt;
    end
  end

  // step control and result register
  always_ff @(posedge clk_pixel) begin
    if (sys_rst) begin
      busy      <= 1'b0;
      step      <= '0;
      com_valid <= 1'b0;
      com       <= COM_EMPTY;
    end else begin
      com_valid <= 1'b0;
      if (busy) begin
        step <= step + 1'b1;
        if (last_step) begin
          // final bit resolves this cycle and is published straight from it
          busy      <= 1'b0;
          com_valid <= 1'b1;
          if (den == '0) begin
            com <= COM_EMPTY;
          end else begin
            com.empty <= 1'b0;
            com.x     <= div_x_nxt.quo[`TRK_X_W-1:0]; // mean never exceeds max coordinate
            com.y     <= div_y_nxt.quo[`TRK_Y_W-1:0];
          end
        end
      end else if (mask.frame_end) begin
        busy <= 1'b1;
        step <= '0;
      end
    end
  end

endmodule

// ==== hw/color_mask.sv ====
`include "tracker_defines.svh"

module color_mask (
  input  logic                    clk_pixel,
  input  logic                    sys_rst,
  input  tracker_pkg::mask_cfg_t  cfg,
  input  video_pkg::pix_beat_t    pix,
  output tracker_pkg::mask_beat_t mask
);
  import video_pkg::*;
  import tracker_pkg::*;

  // stage 1 beat carrying the selected channel value
  typedef struct packed {
    logic                 valid;
    logic                 frame_end;
    logic [`TRK_X_W-1:0]  x;
    logic [`TRK_Y_W-1:0]  y;
    logic [`TRK_CH_W-1:0] chan;
  } chan_beat_t;

  rgb565_t              px;
  logic [`TRK_CH_W-1:0] red8;
  logic [`TRK_CH_W-1:0] green8;
  logic [`TRK_CH_W-1:0] blue8;
  logic [`TRK_CH_W-1:0] luma8;
  logic [`TRK_CH_W-1:0] chan_sel; // channel picked by cfg for stage 1
  chan_beat_t           s1;
  logic                 in_range;

  assign px = pix.pixel;

  // widen 565 to 8 bit channels with zero low bits
  assign red8   = {px.r, 3'b000};
  assign green8 = {px.g, 2'b00};
  assign blue8  = {px.b, 3'b000};

  // cheap luma r/4 + g/2 + b/4 tops out at 250 so no carry out
  assign luma8 = (red8 >> 2) + (green8 >> 1) + (blue8 >> 2);

  always_comb begin
    chan_sel = green8;
    case (cfg.channel)
      GREEN: chan_sel = green8;
      RED:   chan_sel = red8;
      BLUE:  chan_sel = blue8;
      LUMA:  chan_sel = luma8;
    endcase
  end

  // stage 1 registers the selected channel with coordinates and strobes
  always_ff @(posedge clk_pixel) begin
    s1.chan <= chan_sel;
    s1.x    <= pix.x;
    s1.y    <= pix.y;
    if (sys_rst) begin
      s1.valid     <= 1'b0;
      s1.frame_end <= 1'b0;
    end else begin
      s1.valid     <= pix.valid;
      s1.frame_end <= pix.frame_end;
    end
  end

  // both bounds inclusive while cfg stays steady over a frame
  assign in_range = (s1.chan >= cfg.lower) && (s1.chan <= cfg.upper);

  // stage 2 registers the range compare
  always_ff @(posedge clk_pixel) begin
    mask.x <= s1.x;
    mask.y <= s1.y;
    if (sys_rst) begin
      mask.valid     <= 1'b0;
      mask.frame_end <= 1'b0;
      mask.hit       <= 1'b0;
    end else begin
      mask.valid     <= s1.valid;
      mask.frame_end <= s1.frame_end;
      mask.hit       <= s1.valid && in_range; // frame_end beat never hits
    end
  end

endmodule

// ==== hw/color_tracker_top.sv ====
module color_tracker_top (
  input  logic                   clk_pixel,
  input  logic                   sys_rst,
  input  video_pkg::pix_beat_t   pix,
  input  tracker_pkg::mask_cfg_t shirt_cfg,
  input  tracker_pkg::mask_cfg_t saber_cfg,
  output tracker_pkg::bbox_t     bbox,
  output logic                   bbox_valid,
  output tracker_pkg::com_t      com,
  output logic                   com_valid
);
  import tracker_pkg::*;

  mask_beat_t shirt_beat; // 2 cycles behind pix
  mask_beat_t saber_beat;

  // shirt path boxes the marked region
  color_mask shirt_mask_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .cfg       (shirt_cfg),
    .pix       (pix),
    .mask      (shirt_beat)
  );

  bounding_box bounding_box_i (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .mask       (shirt_beat),
    .bbox       (bbox),
    .bbox_valid (bbox_valid) // 3 cycles after frame_end in
  );

  // saber path finds the centroid of the marked pixels
  color_mask saber_mask_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .cfg       (saber_cfg),
    .pix       (pix),
    .mask      (saber_beat)
  );

  center_of_mass center_of_mass_i (
    .clk_pixel (clk_pixel),
    .sys_rst   (sys_rst),
    .mask      (saber_beat),
    .com       (com),
    .com_valid (com_valid) // divider adds TRK_SUM_X_W+1 cycles
  );

endmodule

// ==== hw/tracker_pkg.sv ====
`include "tracker_defines.svh"

package tracker_pkg;

  // channel a mask tests
  typedef enum logic [1:0] {
    GREEN = 2'd0,
    RED   = 2'd1,
    BLUE  = 2'd2,
    LUMA  = 2'd3
  } channel_e;

  // inclusive range test on one channel
  typedef struct packed {
    channel_e             channel;
    logic [`TRK_CH_W-1:0] lower;
    logic [`TRK_CH_W-1:0] upper;
  } mask_cfg_t; // 18 bits

  // mask result travelling with its coordinates
  typedef struct packed {
    logic                valid;
    logic                frame_end;
    logic                hit; // pixel inside the range and low on frame_end
    logic [`TRK_X_W-1:0] x;
    logic [`TRK_Y_W-1:0] y;
  } mask_beat_t; // 24 bits

  typedef struct packed {
    logic                empty; // no marked pixel in the frame
    logic [`TRK_X_W-1:0] x_min;
    logic [`TRK_Y_W-1:0] y_min;
    logic [`TRK_X_W-1:0] x_max;
    logic [`TRK_Y_W-1:0] y_max;
  } bbox_t; // 43 bits

  typedef struct packed {
    logic                empty;
    logic [`TRK_X_W-1:0] x;
    logic [`TRK_Y_W-1:0] y;
  } com_t; // 22 bits

endpackage

// ==== hw/video_pkg.sv ====
`include "tracker_defines.svh"

package video_pkg;

  // packed 565 pixel with red in the top bits
  typedef struct packed {
    logic [4:0] r;
    logic [5:0] g;
    logic [4:0] b;
  } rgb565_t;

  // one beat of the incoming pixel stream
  typedef struct packed {
    logic                valid;     // single cycle pixel strobe
    logic                frame_end; // beat after the last pixel carrying no pixel
    logic [`TRK_X_W-1:0] x;
    logic [`TRK_Y_W-1:0] y;
    rgb565_t             pixel;
  } pix_beat_t; // 39 bits

endpackage

// ==== include/tracker_defines.svh ====
`ifndef TRACKER_DEFINES_SVH
`define TRACKER_DEFINES_SVH

// pixel coordinates sized for a 1280x720 raster
`define TRK_X_W 11 // 0..1279
`define TRK_Y_W 10 // 0..719

// one color channel once 565 is widened
`define TRK_CH_W 8

// marked pixels in one frame with 921600 worst case
`define TRK_CNT_W 20

// coordinate sums when every pixel of a frame is marked
`define TRK_SUM_X_W 31
`define TRK_SUM_Y_W 30

`endif

// ==== testbench/tb_color_tracker.sv ====
`include "tracker_defines.svh"

module tb_color_tracker;
  import video_pkg::*;
  import tracker_pkg::*;

  localparam int FRAME_W    = 16;
  localparam int FRAME_H    = 12;
  localparam int FRAME_PIX  = FRAME_W * FRAME_H;
  localparam int NUM_TESTS  = 6;
  localparam int RST_CYCLES = 16;
  localparam int HALF_CLK   = 20;
  // twice the pixel count plus divider latency per frame with reset on top
  localparam int WATCHDOG_CYCLES = NUM_TESTS * (2 * FRAME_PIX + 64) + RST_CYCLES + 32;

  localparam logic [15:0] BLACK      = 16'h0000;
  localparam logic [15:0] RED_FULL   = 16'hf800; // red8 248 luma 62
  localparam logic [15:0] RED_HALF   = 16'h8000; // red8 128
  localparam logic [15:0] GREEN_FULL = 16'h07e0; // green8 252 luma 126
  localparam logic [15:0] BLUE_FULL  = 16'h001f; // blue8 248 luma 62

  // one row of the test table with frame description and expected results
  typedef struct packed {
    mask_cfg_t   shirt;
    mask_cfg_t   saber;
    logic [15:0] bg;
    logic [15:0] fg; // rectangle color
    logic [3:0]  x0;
    logic [3:0]  x1;
    logic [3:0]  y0;
    logic [3:0]  y1;
    bbox_t       exp_bbox;
    com_t        exp_com;
  } test_row_t;

  logic      clk_pixel;
  logic      sys_rst;
  pix_beat_t pix;
  mask_cfg_t shirt_cfg;
  mask_cfg_t saber_cfg;
  bbox_t     bbox;
  logic      bbox_valid;
  com_t      com;
  logic      com_valid;

  string       test_name [NUM_TESTS];
  test_row_t   table_rows [NUM_TESTS];
  int          bbox_seen = 0; // strobes since reset
  int          com_seen  = 0;
  bbox_t       bbox_got;      // value seen with the last strobe
  com_t        com_got;
  int          pass_cnt  = 0;
  int          fail_cnt  = 0;
  logic [31:0] rng_state;

  color_tracker_top color_tracker_top_i (
    .clk_pixel  (clk_pixel),
    .sys_rst    (sys_rst),
    .pix        (pix),
    .shirt_cfg  (shirt_cfg),
    .saber_cfg  (saber_cfg),
    .bbox       (bbox),
    .bbox_valid (bbox_valid),
    .com        (com),
    .com_valid  (com_valid)
  );

  initial begin
    clk_pixel = 1'b0;
    forever #HALF_CLK clk_pixel = ~clk_pixel;
  end

  // catch strobes mid cycle when outputs have settled
  always @(negedge clk_pixel) begin
    if (bbox_valid === 1'b1) begin
      bbox_seen = bbox_seen + 1;
      bbox_got  = bbox;
    end
    if (com_valid === 1'b1) begin
      com_seen = com_seen + 1;
      com_got  = com;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic mask_cfg_t mask_cfg(input channel_e ch, input int lo, input int hi);
    mask_cfg_t c;
    c.channel = ch;
    c.lower   = `TRK_CH_W'(lo);
    c.upper   = `TRK_CH_W'(hi);
    return c;
  endfunction

  function automatic bbox_t box(input logic e, input int x0, input int y0,
                                input int x1, input int y1);
    bbox_t b;
    b.empty = e;
    b.x_min = `TRK_X_W'(x0);
    b.y_min = `TRK_Y_W'(y0);
    b.x_max = `TRK_X_W'(x1);
    b.y_max = `TRK_Y_W'(y1);
    return b;
  endfunction

  function automatic com_t centroid(input logic e, input int x, input int y);
    com_t c;
    c.empty = e;
    c.x     = `TRK_X_W'(x);
    c.y     = `TRK_Y_W'(y);
    return c;
  endfunction

  function automatic string box_str(input bbox_t b);
    return $sformatf("empty=%0b x %0d..%0d y %0d..%0d", b.empty, b.x_min, b.x_max,
                     b.y_min, b.y_max);
  endfunction

  function automatic string com_str(input com_t c);
    return $sformatf("empty=%0b x %0d y %0d", c.empty, c.x, c.y);
  endfunction

  function automatic rgb565_t pixel_at(input test_row_t r, input int x, input int y);
    if (x >= r.x0 && x <= r.x1 && y >= r.y0 && y <= r.y1) return r.fg;
    return r.bg;
  endfunction

  task automatic add_row(input int idx, input string name, input mask_cfg_t sh,
                         input mask_cfg_t sa, input logic [15:0] bg, input logic [15:0] fg,
                         input int x0, input int x1, input int y0, input int y1,
                         input bbox_t eb, input com_t ec);
    test_name[idx]           = name;
    table_rows[idx].shirt    = sh;
    table_rows[idx].saber    = sa;
    table_rows[idx].bg       = bg;
    table_rows[idx].fg       = fg;
    table_rows[idx].x0       = 4'(x0);
    table_rows[idx].x1       = 4'(x1);
    table_rows[idx].y0       = 4'(y0);
    table_rows[idx].y1       = 4'(y1);
    table_rows[idx].exp_bbox = eb;
    table_rows[idx].exp_com  = ec;
  endtask

  // centroid is floor(sum / count)
  task automatic load_table();
    // 5x4 block with x sum 100 y sum 70 over 20 hits
    add_row(0, "red_rect", mask_cfg(RED, 128, 255), mask_cfg(LUMA, 50, 70),
            BLACK, RED_FULL, 3, 7, 2, 5, box(0, 3, 2, 7, 5), centroid(0, 5, 3));
    add_row(1, "no_hits", mask_cfg(BLUE, 100, 255), mask_cfg(GREEN, 10, 255),
            BLACK, RED_FULL, 3, 7, 2, 5, box(1, 0, 0, 0, 0), centroid(1, 0, 0));
    // green columns 10..15 give 72 hits with x sum 900 y sum 396
    add_row(2, "green_on_blue_green", mask_cfg(GREEN, 200, 255), mask_cfg(LUMA, 100, 130),
            BLUE_FULL, GREEN_FULL, 10, 15, 0, 11, box(0, 10, 0, 15, 11), centroid(0, 12, 5));
    // complement columns 0..9 give 120 hits with x sum 540 y sum 660
    add_row(3, "green_on_blue_blue", mask_cfg(BLUE, 200, 255), mask_cfg(BLUE, 200, 255),
            BLUE_FULL, GREEN_FULL, 10, 15, 0, 11, box(0, 0, 0, 9, 11), centroid(0, 4, 5));
    // red8 128 sits on shirt lower and saber upper bound for 30 hits
    add_row(4, "bounds_inclusive", mask_cfg(RED, 128, 200), mask_cfg(RED, 50, 128),
            BLACK, RED_HALF, 4, 9, 6, 10, box(0, 4, 6, 9, 10), centroid(0, 6, 8));
    add_row(5, "bounds_just_outside", mask_cfg(RED, 129, 255), mask_cfg(RED, 100, 127),
            BLACK, RED_HALF, 4, 9, 6, 10, box(1, 0, 0, 0, 0), centroid(1, 0, 0));
  endtask

  task automatic check_reset_state();
    logic ok;
    ok = 1'b1;
    if (bbox_seen != 0 || com_seen != 0) begin
      $display("a result strobe came out of reset before any frame_end");
      ok = 1'b0;
    end
    if (bbox !== box(1, 0, 0, 0, 0)) begin
      $display("** Error: reset_state bbox expected %s actual %s",
               box_str(box(1, 0, 0, 0, 0)), box_str(bbox));
      ok = 1'b0;
    end
    if (com !== centroid(1, 0, 0)) begin
      $display("** Error: reset_state com expected %s actual %s",
               com_str(centroid(1, 0, 0)), com_str(com));
      ok = 1'b0;
    end
    if (ok) begin
      pass_cnt++;
      $display("test reset_state: ok");
    end else begin
      fail_cnt++;
      $display("test reset_state: failed");
    end
  endtask

  task automatic run_frame(input int idx);
    test_row_t row;
    pix_beat_t beat;
    logic      ok;
    row = table_rows[idx];
    @(negedge clk_pixel);
    shirt_cfg = row.shirt;
    saber_cfg = row.saber;
    for (int y = 0; y < FRAME_H; y++) begin
      for (int x = 0; x < FRAME_W; x++) begin
        rng_state = xorshift32(rng_state);
        if (rng_state[1:0] == 2'b00) begin // idle gap ahead of roughly one pixel in four
          pix = '0;
          @(negedge clk_pixel);
        end
        beat       = '0;
        beat.valid = 1'b1;
        beat.x     = `TRK_X_W'(x);
        beat.y     = `TRK_Y_W'(y);
        beat.pixel = pixel_at(row, x, y);
        pix        = beat;
        @(negedge clk_pixel);
      end
    end
    beat           = '0;
    beat.frame_end = 1'b1; // no pixel on this beat
    pix            = beat;
    @(negedge clk_pixel);
    pix = '0;
    @(posedge clk_pixel);
    while (bbox_seen < idx + 1 || com_seen < idx + 1) @(posedge clk_pixel);
    repeat (4) @(posedge clk_pixel); // room for a stray extra strobe
    ok = 1'b1;
    if (bbox_seen != idx + 1) begin
      $display("** Error: %s bbox_valid count expected %0d actual %0d",
               test_name[idx], idx + 1, bbox_seen);
      ok = 1'b0;
    end
    if (com_seen != idx + 1) begin
      $display("** Error: %s com_valid count expected %0d actual %0d",
               test_name[idx], idx + 1, com_seen);
      ok = 1'b0;
    end
    if (bbox_got !== row.exp_bbox) begin
      $display("** Error: %s bbox expected %s actual %s", test_name[idx],
               box_str(row.exp_bbox), box_str(bbox_got));
      ok = 1'b0;
    end
    if (com_got !== row.exp_com) begin
      $display("** Error: %s com expected %s actual %s", test_name[idx],
               com_str(row.exp_com), com_str(com_got));
      ok = 1'b0;
    end
    if (ok) begin
      pass_cnt++;
      $display("test %s: ok", test_name[idx]);
    end else begin
      fail_cnt++;
      $display("test %s: failed", test_name[idx]);
    end
  endtask

  initial begin
    sys_rst   = 1'b1;
    pix       = '0;
    shirt_cfg = '0;
    saber_cfg = '0;
    rng_state = 32'h8325_420e;
    load_table();
    repeat (RST_CYCLES) @(posedge clk_pixel);
    @(negedge clk_pixel);
    sys_rst = 1'b0;
    repeat (8) @(negedge clk_pixel); // idle so nothing may strobe yet
    check_reset_state();
    for (int i = 0; i < NUM_TESTS; i++) run_frame(i); // frames back to back
    $display("tests passed: %0d failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) $display("RESULT: PASS");
    else $display("RESULT: FAIL");
    $finish;
  end

  // watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_pixel);
    $display("timeout: a bbox_valid or com_valid strobe never came within %0d cycles",
             WATCHDOG_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
